//--- build.f
+incdir+hw
hw/board_pkg.sv
hw/slow_tick_gen.sv
hw/seven_seg_scanner.sv
hw/lab_top.sv
hw/static_seg_driver.sv
hw/board_specific_top.sv
verification/tb_clock_gen.sv
verification/tb_board.sv

//--- verification/tb_board.sv
`default_nettype none

`include "board_macros.svh"

module tb_board
    import board_pkg::*;
();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 5;
    localparam int scan_div     = 2;
    localparam int tick_div     = 16;
    localparam int refresh      = 8 * scan_div + 4;
    localparam int mid_run      = tick_div + tick_div / 2;

    // Board pin codes for 0 to F, active low, segment a in bit 0
    localparam static_digit_t pin_codes [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
        7'h02, 7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

    typedef enum logic [2:0]
    {
        act_idle, act_key0, act_key1, act_both, act_run, act_run_load
    } action_t;

    typedef struct packed
    {
        action_t                act;
        logic [`W_LAB_SW - 1:0] sw;
        int                     cycles;
        logic [`W_VALUE - 1:0]  exp_value;
    } entry_t;

    typedef struct packed
    {
        logic [17:0] ledr;
        logic [8:0]  ledg;
    } led_t;

    logic                   clk;
    logic                   rst;
    logic [`W_KEY - 1:0]    key;
    logic [`W_LAB_SW - 1:0] sw;
    logic [17:0]            ledr;
    logic [8:0]             ledg;
    hex_bank_t              hex;

    entry_t                 tests[$];
    logic [31:0]            rng_state = 32'hbc62_3e84;
    logic [`W_VALUE - 1:0]  model_value;
    bit                     table_built = 1'b0;

    tb_clock_gen #(.period(clk_period), .reset_cycles(reset_cycles)) i_clock
    (
        .clk ( clk ),
        .rst ( rst )
    );

    board_specific_top #(.scan_div(scan_div), .tick_div(tick_div)) dut0
    (
        .clk  ( clk  ),
        .rst  ( rst  ),
        .key  ( key  ),
        .sw   ( sw   ),
        .ledr ( ledr ),
        .ledg ( ledg ),
        .hex  ( hex  )
    );

    //--------------------
    // Reference model

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [15:0] random_half();
        rng_state = xorshift32(rng_state);
        return rng_state[15:0];
    endfunction

    function automatic hex_bank_t expected_hex(input logic [`W_VALUE - 1:0] v);
        hex_bank_t r;
        for (int i = 0; i < `W_DIGIT; i++)
            r[i] = pin_codes[v[4 * i +: 4]];
        return r;
    endfunction

    function automatic led_t expected_led(input logic [`W_VALUE - 1:0] v, input logic dp0);
        led_t r;
        r.ledr = {7'b0, dp0, 10'b0};
        r.ledg = {1'b0, v[7:0]};
        return r;
    endfunction

    // Active-low key pins for the press of an entry
    function automatic logic [`W_KEY - 1:0] key_pins(input action_t act);
        case (act)
            act_key0: return 4'b1110;
            act_key1: return 4'b1101;
            act_both: return 4'b1100;
            default:  return 4'b1111;
        endcase
    endfunction

    // A load in the last tick cycle replaces the high half instead of counting
    task automatic add_entry(input action_t act, input logic [15:0] sw_lo, input int cycles);
        entry_t e;
        logic [`W_VALUE - 1:0] n;
        logic [`W_VALUE - 1:0] counted;
        n = model_value;
        counted = model_value + `W_VALUE'(cycles / tick_div);
        case (act)
            act_key0:     n[15:0] = sw_lo;
            act_key1:     n[31:16] = sw_lo;
            act_both:     n = {sw_lo, sw_lo};
            act_run:      n = counted;
            act_run_load: n = {sw_lo, 16'(counted - 1'b1)};
            default:      n = model_value;
        endcase
        e.act       = act;
        e.sw        = {(act == act_run || act == act_run_load), sw_lo};
        e.cycles    = cycles;
        e.exp_value = n;
        model_value = n;
        tests.push_back(e);
    endtask

    task automatic build_table();
        model_value = '0;
        add_entry(act_idle,     16'h0000,      1);
        add_entry(act_key0,     random_half(), 1);
        add_entry(act_key1,     random_half(), 1);
        add_entry(act_both,     random_half(), 1);
        add_entry(act_key0,     random_half(), 1);
        add_entry(act_key1,     random_half(), 1);
        add_entry(act_idle,     random_half(), 6);
        add_entry(act_run,      random_half(), 3 * tick_div);
        add_entry(act_both,     16'hffff,      1);
        add_entry(act_key0,     16'hfffe,      1);
        add_entry(act_run,      16'h0000,      3 * tick_div);
        add_entry(act_run_load, random_half(), 2 * tick_div);
        add_entry(act_key1,     random_half(), 1);
        add_entry(act_run,      random_half(), 2 * tick_div);
        table_built = 1'b1;
    endtask

    //--------------------
    // Checks

    task automatic check_hex(input hex_bank_t exp);
        if (hex !== exp)
        begin
            $display("** Error at time %0t: hex expected %h, actual %h", $time, exp, hex);
            $display("TEST FAIL");
            $fatal(1, "Display mismatch");
        end
    endtask

    task automatic check_led(input led_t exp);
        led_t act;
        act.ledr = ledr;
        act.ledg = ledg;
        if (act !== exp)
        begin
            $display("** Error at time %0t: ledr/ledg expected %h, actual %h",
                $time, exp, act);
            $display("TEST FAIL");
            $fatal(1, "LED mismatch");
        end
    endtask

    // Press lasts one cycle, a run holds sw[16] for the whole tick span
    task automatic apply_entry(input entry_t e, input logic [`W_VALUE - 1:0] prev);
        @(posedge clk);
        sw  <= e.sw;
        key <= key_pins(e.act);
        for (int i = 1; i <= e.cycles; i++)
        begin
            @(posedge clk);
            if (i == e.cycles)
            begin
                sw  <= {1'b0, e.sw[15:0]};
                key <= (e.act == act_run_load) ? key_pins(act_key1) : 4'b1111;
            end
            if (e.act == act_run && i == mid_run && e.cycles > mid_run)
            begin
                @(negedge clk);
                check_led(expected_led(prev + 1, 1'b1));
            end
        end
        if (e.act == act_run_load)
        begin
            @(posedge clk);
            key <= 4'b1111;
        end
        repeat (refresh)
            @(posedge clk);
        @(negedge clk);
        check_hex(expected_hex(e.exp_value));
        check_led(expected_led(e.exp_value, 1'b0));
    endtask

    //--------------------
    // Run

    initial
    begin
        logic [`W_VALUE - 1:0] prev;
        key = 4'b1111;
        sw  = '0;
        build_table();
        wait (rst === 1'b1);
        @(posedge clk);
        @(negedge clk);
        // Blank display while reset is held
        check_hex('1);
        check_led('0);
        while (rst)
            @(posedge clk);
        prev = '0;
        foreach (tests[i])
        begin
            apply_entry(tests[i], prev);
            prev = tests[i].exp_value;
        end
        $display("TEST PASS");
        $finish;
    end

    initial
    begin
        int limit;
        wait (table_built);
        limit = reset_cycles + 200;
        foreach (tests[i])
            limit += tests[i].cycles + refresh + 3;
        #(limit * clk_period);
        $display("The run timed out after %0d cycles", limit);
        $display("TEST FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen
#(
    parameter int period       = 40,
    parameter int reset_cycles = 5
)
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period / 2) clk = ~clk;
    end

    // Reset drops on a rising edge once the count is reached
    initial
    begin
        rst = 1'b1;
        repeat (reset_cycles)
            @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- hw/board_specific_top.sv
`default_nettype none

`include "board_macros.svh"

module board_specific_top
    import board_pkg::*;
#(
    parameter int scan_div = `SCAN_DIV_DEFAULT,
    parameter int tick_div = `TICK_DIV_DEFAULT
)
(
    input  logic                   clk,
    input  logic                   rst,

    // Push buttons read low when pressed
    input  logic [`W_KEY - 1:0]    key,
    input  logic [`W_LAB_SW - 1:0] sw,

    output logic [17:0]            ledr,
    output logic [8:0]             ledg,

    output hex_bank_t              hex
);

    localparam int w_lab_led = 8;

    logic [`W_KEY - 1:0]    lab_key;
    logic [w_lab_led - 1:0] lab_led;
    logic [`W_DIGIT - 1:0]  dp_led;
    scan_t                  scan;

    //--------------------
    // Inputs

    assign lab_key = ~key;

    //--------------------
    // Lab logic

    lab_top
    #(
        .scan_div ( scan_div ),
        .tick_div ( tick_div )
    )
    i_lab_top
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .key      ( lab_key  ),
        .sw       ( sw       ),
        .lab_led  ( lab_led  ),
        .scan     ( scan     )
    );

    //--------------------
    // Static seven-segment display

    static_seg_driver i_static_seg
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .scan     ( scan     ),
        .hex      ( hex      ),
        .dp_led   ( dp_led   )
    );

    //--------------------
    // LED placement

    // Green LEDs show the low byte, the spare one stays dark
    assign ledg = {{($bits(ledg) - w_lab_led){1'b0}}, lab_led};

    // Decimal points go to the top red LEDs, dp of HEX0 on ledr[10]
    assign ledr = {dp_led, {($bits(ledr) - `W_DIGIT){1'b0}}};

endmodule

`default_nettype wire

//--- hw/static_seg_driver.sv
`default_nettype none

`include "board_macros.svh"

module static_seg_driver
    import board_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  scan_t                 scan,
    output hex_bank_t             hex,
    output logic [`W_DIGIT - 1:0] dp_led
);

    logic [$bits(segment_t) - 1:0] abcdefgh;
    logic [$bits(segment_t) - 1:0] hgfedcba;
    static_digit_t                 pattern;
    logic                          dp_bit;

    //--------------------
    // Pin order

    assign abcdefgh = scan.seg;

    // Mirror the byte so segment a lands in bit 0
    always_comb
    begin
        for (int i = 0; i < $bits(segment_t); i++)
            hgfedcba[i] = abcdefgh[$bits(segment_t) - 1 - i];
    end

    // Board segments light on a low level
    assign pattern = ~hgfedcba[$bits(static_digit_t) - 1:0];
    assign dp_bit  = hgfedcba[$bits(segment_t) - 1];

    //--------------------
    // Sticky digit registers

    // Each digit keeps what it last showed until the scan comes round again
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hex    <= '1;
            dp_led <= '0;
        end
        else
        begin
            for (int i = 0; i < `W_DIGIT; i++)
            begin
                if (scan.digit[i])
                begin
                    hex[i]    <= pattern;
                    dp_led[i] <= dp_bit;
                end
            end
        end
    end

    // More than one select bit would write one pattern into several digits
    a_scan_onehot0: assert property (@(posedge clk) disable iff (rst)
        $onehot0(scan.digit));

endmodule

`default_nettype wire

//--- hw/lab_top.sv
`default_nettype none

`include "board_macros.svh"

module lab_top
    import board_pkg::*;
#(
    parameter int scan_div = `SCAN_DIV_DEFAULT,
    parameter int tick_div = `TICK_DIV_DEFAULT
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`W_KEY - 1:0]    key,
    input  logic [`W_LAB_SW - 1:0] sw,
    output logic [7:0]             lab_led,
    output scan_t                  scan
);

    localparam int w_half = `W_VALUE / 2;

    logic                  run;
    logic                  tick;
    logic                  load_lo;
    logic                  load_hi;
    logic [`W_VALUE - 1:0] value;
    logic [`W_DIGIT - 1:0] dp;

    // Top switch is run, the rest feed the loads
    assign run     = sw[`W_LAB_SW - 1];
    assign load_lo = key[0];
    assign load_hi = key[1];

    //--------------------
    // Run tick

    slow_tick_gen
    #(
        .tick_div ( tick_div )
    )
    i_tick
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .run      ( run      ),
        .tick     ( tick     )
    );

    //--------------------
    // Value register

    // Any load in a tick cycle cancels the increment
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            value <= '0;
        end
        else if (load_lo || load_hi)
        begin
            if (load_lo)
                value[w_half - 1:0] <= sw[w_half - 1:0];
            if (load_hi)
                value[`W_VALUE - 1:w_half] <= sw[w_half - 1:0];
        end
        else if (tick)
        begin
            value <= value + 1'b1;
        end
    end

    //--------------------
    // Display and LEDs

    // Only digit 0 carries a point, lit while counting
    assign dp      = {{(`W_DIGIT - 1){1'b0}}, run};
    assign lab_led = value[7:0];

    seven_seg_scanner
    #(
        .scan_div ( scan_div )
    )
    i_scanner
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .value    ( value    ),
        .dp       ( dp       ),
        .scan     ( scan     )
    );

endmodule

`default_nettype wire

//--- hw/seven_seg_scanner.sv
`default_nettype none

`include "board_macros.svh"

module seven_seg_scanner
    import board_pkg::*;
#(
    parameter int scan_div = `SCAN_DIV_DEFAULT
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`W_VALUE - 1:0] value,
    input  logic [`W_DIGIT - 1:0] dp,
    output scan_t                 scan
);

    localparam int w_pre = (scan_div > 1) ? $clog2(scan_div) : 1;

    localparam logic [w_pre - 1:0] pre_reload = w_pre'(scan_div - 1);

    logic [w_pre - 1:0]    pre;
    logic [`W_DIGIT - 1:0] digit;
    logic [3:0]            nibble;
    logic                  dp_sel;

    // Hex digit to abcdefg, a in the MSB
    function automatic logic [6:0] hex_to_abcdefg(input logic [3:0] hex);
        case (hex)
            4'h0:    return 7'b1111110;
            4'h1:    return 7'b0110000;
            4'h2:    return 7'b1101101;
            4'h3:    return 7'b1111001;
            4'h4:    return 7'b0110011;
            4'h5:    return 7'b1011011;
            4'h6:    return 7'b1011111;
            4'h7:    return 7'b1110000;
            4'h8:    return 7'b1111111;
            4'h9:    return 7'b1111011;
            4'ha:    return 7'b1110111;
            4'hb:    return 7'b0011111;
            4'hc:    return 7'b1001110;
            4'hd:    return 7'b0111101;
            4'he:    return 7'b1001111;
            default: return 7'b1000111;
        endcase
    endfunction

    //--------------------
    // Digit rotation

    // The select is empty for the first cycle out of reset, then one-hot from digit 0
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pre   <= pre_reload;
            digit <= '0;
        end
        else if (digit == '0)
        begin
            pre   <= pre_reload;
            digit <= `W_DIGIT'(1);
        end
        else if (pre == '0)
        begin
            pre   <= pre_reload;
            digit <= {digit[`W_DIGIT - 2:0], digit[`W_DIGIT - 1]};
        end
        else
        begin
            pre <= pre - 1'b1;
        end
    end

    //--------------------
    // Pattern of the selected digit

    always_comb
    begin
        nibble = '0;
        dp_sel = 1'b0;
        for (int i = 0; i < `W_DIGIT; i++)
        begin
            if (digit[i])
            begin
                nibble = value[4 * i +: 4];
                dp_sel = dp[i];
            end
        end
    end

    assign scan.digit = digit;
    assign scan.seg   = {hex_to_abcdefg(nibble), dp_sel};

    a_digit_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(scan.digit));

    // Only the single cycle right after reset may have an empty select
    a_digit_live: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> scan.digit != '0);

endmodule

`default_nettype wire

//--- hw/slow_tick_gen.sv
`default_nettype none

`include "board_macros.svh"

module slow_tick_gen
#(
    parameter int tick_div = `TICK_DIV_DEFAULT
)
(
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic tick
);

    localparam int w_cnt = (tick_div > 1) ? $clog2(tick_div) : 1;

    localparam logic [w_cnt - 1:0] cnt_reload = w_cnt'(tick_div - 1);

    logic [w_cnt - 1:0] cnt;

    // Held at the reload value while run is off, so each run phase starts a full period
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt  <= cnt_reload;
            tick <= 1'b0;
        end
        else if (!run)
        begin
            cnt  <= cnt_reload;
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= cnt_reload;
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    // A strobe, never a level, once the divider is real
    a_tick_strobe: assert property (@(posedge clk) disable iff (rst)
        (tick_div > 1) && tick |=> !tick);

endmodule

`default_nettype wire

//--- hw/board_pkg.sv
`default_nettype none

`include "board_macros.svh"

package board_pkg;

    //--------------------
    // Dynamic display side

    // Active-high segments in abcdefgh order, a is the MSB, h is the decimal point
    typedef struct packed
    {
        logic a;
        logic b;
        logic c;
        logic d;
        logic e;
        logic f;
        logic g;
        logic h;
    } segment_t;

    // One-hot digit select with the pattern of the selected digit
    typedef struct packed
    {
        logic [`W_DIGIT - 1:0] digit;
        segment_t              seg;
    } scan_t;

    //--------------------
    // Static display side

    // Active-low pin pattern, segment a in bit 0 and g in bit 6
    typedef logic [6:0] static_digit_t;

    // HEX0 is element 0
    typedef static_digit_t [`W_DIGIT - 1:0] hex_bank_t;

endpackage

`default_nettype wire

//--- hw/board_macros.svh
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// Board geometry

`define W_DIGIT   8
`define W_LAB_SW  17
`define W_KEY     4
`define W_VALUE   32

//--------------------
// Divider defaults for a 50 MHz board clock

// About 1 ms per scan step
`define SCAN_DIV_DEFAULT  50000

// About 5 counts per second while run is on
`define TICK_DIV_DEFAULT  10000000

`endif
